//--- microcodedControl.f
src/microcodedPkg.sv
src/microstore.sv
src/microsequencer.sv
src/instructionRegister.sv
src/controlUnit.sv
tb/controlChecker.sv
tb/controlUnitTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f microcodedControl.f --top-module controlUnitTb -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/controlUnitSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

// top of the microprogrammed control unit
// flat tree of sequencer, rom and instruction register
module controlUnit (
    input  wire                                          clk,
    input  wire                                          reset,
    // memory read data
    input  wire logic [microcodedPkg::instrWidth-1:0]    instruction,
    // access of this cycle completes
    input  wire                                          memReady,
    // control levels to the datapath
    output logic      [microcodedPkg::controlWidth-1:0]  controlWord,
    output logic      [microcodedPkg::stateWidth-1:0]    activeState,
    // decoded fields
    output logic      [microcodedPkg::fieldWidth-1:0]    opcode,
    output logic      [microcodedPkg::fieldWidth-1:0]    rd,
    output logic      [microcodedPkg::fieldWidth-1:0]    rs,
    output logic      [microcodedPkg::fieldWidth-1:0]    rt,
    output logic      [microcodedPkg::immWidth-1:0]      imm
);

    // registered microstate into the rom
    logic [microcodedPkg::stateWidth-1:0] currentState;

    // next-state logic
    // reads the word and activeState back from the rom
    microsequencer sequencer0 (
        .clk          (clk),
        .reset        (reset),
        .controlWord  (controlWord),
        .activeState  (activeState),
        .opcode       (opcode),
        .memReady     (memReady),
        .currentState (currentState)
    );

    // control word for this cycle
    // addressed by the registered microstate
    microstore store0 (
        .currentState (currentState),
        .controlWord  (controlWord),
        .activeState  (activeState)
    );

    // latches on irLoad
    // opcode feeds dispatch as well as the port
    instructionRegister ir0 (
        .clk         (clk),
        .reset       (reset),
        .controlWord (controlWord),
        .instruction (instruction),
        .opcode      (opcode),
        .rd          (rd),
        .rs          (rs),
        .rt          (rt),
        .imm         (imm)
    );

endmodule

`default_nettype wire

//--- src/instructionRegister.sv
`timescale 1ns/1ps
`default_nettype none

// instruction latch and field decode
module instructionRegister (
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire logic [microcodedPkg::controlWidth-1:0]  controlWord,
    input  wire logic [microcodedPkg::instrWidth-1:0]    instruction,
    output logic      [microcodedPkg::fieldWidth-1:0]    opcode,
    output logic      [microcodedPkg::fieldWidth-1:0]    rd,
    output logic      [microcodedPkg::fieldWidth-1:0]    rs,
    output logic      [microcodedPkg::fieldWidth-1:0]    rt,
    output logic      [microcodedPkg::immWidth-1:0]      imm
);

    // latched word, read through either view
    microcodedPkg::instructionT current;
    logic                       load;

    // irLoad strobe from the microstore
    assign load = controlWord[microcodedPkg::irLoadBit];

    // capture at the end of stIrLoad
    // fields are valid from stDecode on
    always_ff @(posedge clk) begin
        if (reset) begin
            current <= '0;
        end else if (load) begin
            current <= instruction;
        end
    end

    // register format fields
    assign opcode = current.r.opcode;
    assign rd     = current.r.rd;
    assign rs     = current.r.rs;
    assign rt     = current.r.rt;

    // immediate format field
    // overlaps rs and rt, datapath picks with aluSrcImm
    assign imm = current.i.imm;

    // memory data must be clean when it is captured
    // otherwise dispatch in stDecode goes wrong one cycle later
    property cleanLoad;
        @(posedge clk) disable iff (reset)
        load |-> !$isunknown(instruction);
    endproperty

    assert property (cleanLoad)
        else $error("instruction has unknown bits at irLoad");

endmodule

`default_nettype wire

//--- src/microcodedPkg.sv
`default_nettype none

// shared widths, control word layout and instruction format
package microcodedPkg;

    // widths fixed by the instruction set
    localparam int stateWidth   = 7;
    localparam int controlWidth = 45;
    localparam int instrWidth   = 16;
    localparam int fieldWidth   = 4;
    localparam int immWidth     = 8;
    localparam int aluOpWidth   = 4;
    localparam int seqModeWidth = 2;

    // control word layout, low bits first
    // sequencing fields sit at the bottom of the word
    localparam int seqModeLsb     = 0;
    localparam int nextStateLsb   = seqModeLsb + seqModeWidth;
    // one-cycle datapath strobes
    localparam int memReadBit     = nextStateLsb + stateWidth;
    localparam int memWriteBit    = memReadBit + 1;
    localparam int irLoadBit      = memWriteBit + 1;
    localparam int pcIncrementBit = irLoadBit + 1;
    localparam int pcLoadBit      = pcIncrementBit + 1;
    localparam int regWriteBit    = pcLoadBit + 1;
    localparam int aluSrcImmBit   = regWriteBit + 1;
    localparam int aluOpLsb       = aluSrcImmBit + 1;
    // everything from here up is reserved, always zero
    localparam int reservedLsb    = aluOpLsb + aluOpWidth;

    // how the sequencer picks the next microstate
    typedef enum logic [seqModeWidth-1:0] {
        seqNext     = 2'd0,
        seqJump     = 2'd1,
        seqDispatch = 2'd2,
        seqWaitMem  = 2'd3
    } seqModeT;

    // microstate numbers
    // fetch path
    localparam logic [stateWidth-1:0] stFetch     = 7'd0;
    localparam logic [stateWidth-1:0] stFetchWait = 7'd1;
    localparam logic [stateWidth-1:0] stIrLoad    = 7'd2;
    localparam logic [stateWidth-1:0] stDecode    = 7'd3;
    // execute paths
    localparam logic [stateWidth-1:0] stAluReg    = 7'd4;
    localparam logic [stateWidth-1:0] stAluImm    = 7'd5;
    localparam logic [stateWidth-1:0] stLoadAddr  = 7'd6;
    localparam logic [stateWidth-1:0] stLoadWait  = 7'd7;
    localparam logic [stateWidth-1:0] stLoadBack  = 7'd8;
    localparam logic [stateWidth-1:0] stStore     = 7'd9;
    localparam logic [stateWidth-1:0] stStoreWait = 7'd10;
    localparam logic [stateWidth-1:0] stJump      = 7'd11;
    localparam logic [stateWidth-1:0] stHalt      = 7'd12;
    // highest defined microstate
    localparam logic [stateWidth-1:0] lastState   = stHalt;

    // alu op driven in both alu states (add)
    localparam logic [aluOpWidth-1:0] aluOpcode = 4'd1;

    // one instruction word, two field layouts
    // opcode and rd line up in both views
    typedef union packed {
        struct packed {
            logic [fieldWidth-1:0] opcode;
            logic [fieldWidth-1:0] rd;
            logic [fieldWidth-1:0] rs;
            logic [fieldWidth-1:0] rt;
        } r;
        struct packed {
            logic [fieldWidth-1:0] opcode;
            logic [fieldWidth-1:0] rd;
            logic [immWidth-1:0]   imm;
        } i;
    } instructionT;

endpackage

`default_nettype wire

//--- src/microsequencer.sv
`timescale 1ns/1ps
`default_nettype none

// microstate register and next-state selection
module microsequencer (
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire logic [microcodedPkg::controlWidth-1:0]  controlWord,
    input  wire logic [microcodedPkg::stateWidth-1:0]    activeState,
    input  wire logic [microcodedPkg::fieldWidth-1:0]    opcode,
    input  wire                                          memReady,
    output logic      [microcodedPkg::stateWidth-1:0]    currentState
);

    localparam int sw = microcodedPkg::stateWidth;

    // dispatch target for opcodes 11 to 14
    // first number past the rom, microstore falls back from it
    localparam logic [sw-1:0] illegalTarget = microcodedPkg::lastState + 7'd1;

    microcodedPkg::seqModeT seqMode;
    logic [sw-1:0]          target;
    logic [sw-1:0]          nextState;

    // sequencing fields of the current word
    assign seqMode = microcodedPkg::seqModeT'(
        controlWord[microcodedPkg::seqModeLsb +: microcodedPkg::seqModeWidth]);
    assign target  = controlWord[microcodedPkg::nextStateLsb +: sw];

    // opcode dispatch table
    function automatic logic [sw-1:0] dispatchTarget(
        input logic [microcodedPkg::fieldWidth-1:0] op
    );
        logic [sw-1:0] state;
        case (op) inside
            [4'd0:4'd3]:  state = microcodedPkg::stAluReg;
            [4'd4:4'd7]:  state = microcodedPkg::stAluImm;
            4'd8:         state = microcodedPkg::stLoadAddr;
            4'd9:         state = microcodedPkg::stStore;
            4'd10:        state = microcodedPkg::stJump;
            4'd15:        state = microcodedPkg::stHalt;
            // 11 to 14 have no microcode
            default:      state = illegalTarget;
        endcase
        return state;
    endfunction

    always_comb begin
        // activeState, not currentState, so undefined states resume as fetch
        unique case (seqMode)
            microcodedPkg::seqNext:
                nextState = activeState + 7'd1;
            microcodedPkg::seqJump:
                nextState = target;
            microcodedPkg::seqDispatch:
                nextState = dispatchTarget(opcode);
            // stall until the access completes
            microcodedPkg::seqWaitMem:
                nextState = memReady ? target : activeState;
        endcase
    end

    // microstate register
    always_ff @(posedge clk) begin
        if (reset) begin
            currentState <= microcodedPkg::stFetch;
        end else begin
            currentState <= nextState;
        end
    end

    // progress check
    // a stall is only legal while waiting on memory, or when halted
    property stateAdvances;
        @(posedge clk) disable iff (reset)
        !((seqMode == microcodedPkg::seqWaitMem) && !memReady) &&
        (activeState != microcodedPkg::stHalt)
        |=> currentState != $past(currentState);
    endproperty

    assert property (stateAdvances)
        else $error("microstate %0d repeated without a stall", currentState);

endmodule

`default_nettype wire

//--- src/microstore.sv
`timescale 1ns/1ps
`default_nettype none

// microprogram rom
// purely combinational with state in and control word out
module microstore (
    input  wire logic [microcodedPkg::stateWidth-1:0]   currentState,
    output logic      [microcodedPkg::controlWidth-1:0] controlWord,
    output logic      [microcodedPkg::stateWidth-1:0]   activeState
);

    // short local names for the two widths
    localparam int cw = microcodedPkg::controlWidth;
    localparam int sw = microcodedPkg::stateWidth;

    // single-bit strobe masks
    localparam logic [cw-1:0] memRead     = cw'(1) << microcodedPkg::memReadBit;
    localparam logic [cw-1:0] memWrite    = cw'(1) << microcodedPkg::memWriteBit;
    localparam logic [cw-1:0] irLoad      = cw'(1) << microcodedPkg::irLoadBit;
    localparam logic [cw-1:0] pcIncrement = cw'(1) << microcodedPkg::pcIncrementBit;
    localparam logic [cw-1:0] pcLoad      = cw'(1) << microcodedPkg::pcLoadBit;
    localparam logic [cw-1:0] regWrite    = cw'(1) << microcodedPkg::regWriteBit;
    localparam logic [cw-1:0] aluSrcImm   = cw'(1) << microcodedPkg::aluSrcImmBit;
    // alu op field already shifted into place
    localparam logic [cw-1:0] aluOp =
        cw'(microcodedPkg::aluOpcode) << microcodedPkg::aluOpLsb;

    // merge sequencing fields into a set of strobes
    function automatic logic [cw-1:0] microWord(
        input microcodedPkg::seqModeT mode,
        input logic [sw-1:0]          target,
        input logic [cw-1:0]          strobes
    );
        logic [cw-1:0] word;
        word = strobes;
        word[microcodedPkg::seqModeLsb +: microcodedPkg::seqModeWidth] = mode;
        word[microcodedPkg::nextStateLsb +: sw] = target;
        return word;
    endfunction

    // fetch word and fallback for undefined states
    localparam logic [cw-1:0] fetchWord =
        microWord(microcodedPkg::seqNext, microcodedPkg::stFetch, memRead);

    always_comb begin
        // defined states report themselves
        activeState = currentState;
        case (currentState)
            // instruction fetch
            microcodedPkg::stFetch:
                controlWord = fetchWord;
            // hold the read until memory answers
            microcodedPkg::stFetchWait:
                controlWord = microWord(microcodedPkg::seqWaitMem,
                                        microcodedPkg::stIrLoad, memRead);
            microcodedPkg::stIrLoad:
                controlWord = microWord(microcodedPkg::seqNext, '0,
                                        irLoad | pcIncrement);
            // opcode table picks the execute path
            microcodedPkg::stDecode:
                controlWord = microWord(microcodedPkg::seqDispatch, '0, '0);
            // register and immediate alu ops
            microcodedPkg::stAluReg:
                controlWord = microWord(microcodedPkg::seqJump,
                                        microcodedPkg::stFetch, regWrite | aluOp);
            microcodedPkg::stAluImm:
                controlWord = microWord(microcodedPkg::seqJump,
                                        microcodedPkg::stFetch,
                                        regWrite | aluSrcImm | aluOp);
            // load takes three states
            microcodedPkg::stLoadAddr:
                controlWord = microWord(microcodedPkg::seqNext, '0, memRead);
            microcodedPkg::stLoadWait:
                controlWord = microWord(microcodedPkg::seqWaitMem,
                                        microcodedPkg::stLoadBack, memRead);
            microcodedPkg::stLoadBack:
                controlWord = microWord(microcodedPkg::seqJump,
                                        microcodedPkg::stFetch, regWrite);
            // store holds the write through the wait
            microcodedPkg::stStore:
                controlWord = microWord(microcodedPkg::seqNext, '0, memWrite);
            microcodedPkg::stStoreWait:
                controlWord = microWord(microcodedPkg::seqWaitMem,
                                        microcodedPkg::stFetch, memWrite);
            microcodedPkg::stJump:
                controlWord = microWord(microcodedPkg::seqJump,
                                        microcodedPkg::stFetch, pcLoad);
            // halt jumps to itself
            microcodedPkg::stHalt:
                controlWord = microWord(microcodedPkg::seqJump,
                                        microcodedPkg::stHalt, '0);
            // undefined states behave as fetch and say so
            default: begin
                controlWord = fetchWord;
                activeState = microcodedPkg::stFetch;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- tb/controlChecker.sv
`timescale 1ns/1ps
`default_nettype none

// cycle model of the control unit
// compares the DUT on every rising edge
module controlChecker (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire logic [microcodedPkg::instrWidth-1:0]    instruction,
    input  wire logic                                    memReady,
    input  wire logic [microcodedPkg::controlWidth-1:0]  controlWord,
    input  wire logic [microcodedPkg::stateWidth-1:0]    activeState,
    input  wire logic [3:0]                              opcode,
    input  wire logic [3:0]                              rd,
    input  wire logic [3:0]                              rs,
    input  wire logic [3:0]                              rt,
    input  wire logic [7:0]                              imm,
    // which test is running, and its end strobe
    input  wire logic [2:0]                              testIndex,
    input  wire logic                                    testEnd,
    output int                                           checkCount,
    output int                                           errorCount
);

    localparam int cw = microcodedPkg::controlWidth;
    localparam int sw = microcodedPkg::stateWidth;

    // model of the microstate and the instruction latch
    logic [sw-1:0]                        modelState;
    logic [microcodedPkg::instrWidth-1:0] modelIr;
    logic                                 modelValid = 1'b0;
    int checks = 0;
    int errors = 0;
    int testChecks = 0;
    int testErrors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    function automatic string testName(input logic [2:0] index);
        case (index)
            3'd0: return "resetState";
            3'd1: return "fetchDecode";
            3'd2: return "memoryWait";
            3'd3: return "aluAndJump";
            3'd4: return "illegalOpcode";
            3'd5: return "haltHold";
            default: return "unknown";
        endcase
    endfunction

    // microprogram table, one row per state
    function automatic logic [cw-1:0] expectedWord(input logic [sw-1:0] state);
        logic [cw-1:0]          word;
        microcodedPkg::seqModeT mode;
        logic [sw-1:0]          target;
        word = '0;
        mode = microcodedPkg::seqNext;
        target = microcodedPkg::stFetch;
        case (state)
            microcodedPkg::stFetch: begin
                word[microcodedPkg::memReadBit] = 1'b1;
            end
            microcodedPkg::stFetchWait: begin
                word[microcodedPkg::memReadBit] = 1'b1;
                mode = microcodedPkg::seqWaitMem;
                target = microcodedPkg::stIrLoad;
            end
            microcodedPkg::stIrLoad: begin
                word[microcodedPkg::irLoadBit] = 1'b1;
                word[microcodedPkg::pcIncrementBit] = 1'b1;
            end
            microcodedPkg::stDecode: begin
                mode = microcodedPkg::seqDispatch;
            end
            microcodedPkg::stAluReg: begin
                word[microcodedPkg::regWriteBit] = 1'b1;
                word[microcodedPkg::aluOpLsb +: 4] = microcodedPkg::aluOpcode;
                mode = microcodedPkg::seqJump;
            end
            microcodedPkg::stAluImm: begin
                word[microcodedPkg::regWriteBit] = 1'b1;
                word[microcodedPkg::aluSrcImmBit] = 1'b1;
                word[microcodedPkg::aluOpLsb +: 4] = microcodedPkg::aluOpcode;
                mode = microcodedPkg::seqJump;
            end
            microcodedPkg::stLoadAddr: begin
                word[microcodedPkg::memReadBit] = 1'b1;
            end
            microcodedPkg::stLoadWait: begin
                word[microcodedPkg::memReadBit] = 1'b1;
                mode = microcodedPkg::seqWaitMem;
                target = microcodedPkg::stLoadBack;
            end
            microcodedPkg::stLoadBack: begin
                word[microcodedPkg::regWriteBit] = 1'b1;
                mode = microcodedPkg::seqJump;
            end
            microcodedPkg::stStore: begin
                word[microcodedPkg::memWriteBit] = 1'b1;
            end
            microcodedPkg::stStoreWait: begin
                word[microcodedPkg::memWriteBit] = 1'b1;
                mode = microcodedPkg::seqWaitMem;
            end
            microcodedPkg::stJump: begin
                word[microcodedPkg::pcLoadBit] = 1'b1;
                mode = microcodedPkg::seqJump;
            end
            microcodedPkg::stHalt: begin
                mode = microcodedPkg::seqJump;
                target = microcodedPkg::stHalt;
            end
            default: begin
                // never expected, shows up as a mismatch
                word = '1;
            end
        endcase
        word[microcodedPkg::seqModeLsb +: microcodedPkg::seqModeWidth] = mode;
        word[microcodedPkg::nextStateLsb +: sw] = target;
        return word;
    endfunction

    // opcode table, 11 to 14 go to undefined state 13
    function automatic logic [sw-1:0] dispatchState(input logic [3:0] op);
        logic [sw-1:0] state;
        if (op <= 4'd3) state = microcodedPkg::stAluReg;
        else if (op <= 4'd7) state = microcodedPkg::stAluImm;
        else if (op == 4'd8) state = microcodedPkg::stLoadAddr;
        else if (op == 4'd9) state = microcodedPkg::stStore;
        else if (op == 4'd10) state = microcodedPkg::stJump;
        else if (op == 4'd15) state = microcodedPkg::stHalt;
        else state = 7'd13;
        return state;
    endfunction

    function automatic logic [sw-1:0] nextModelState(
        input logic [sw-1:0] state,
        input logic          ready,
        input logic [3:0]    op
    );
        logic [sw-1:0] next;
        case (state)
            microcodedPkg::stFetchWait:
                next = ready ? microcodedPkg::stIrLoad : microcodedPkg::stFetchWait;
            microcodedPkg::stDecode:
                next = dispatchState(op);
            microcodedPkg::stLoadWait:
                next = ready ? microcodedPkg::stLoadBack : microcodedPkg::stLoadWait;
            microcodedPkg::stStoreWait:
                next = ready ? microcodedPkg::stFetch : microcodedPkg::stStoreWait;
            microcodedPkg::stAluReg, microcodedPkg::stAluImm,
            microcodedPkg::stLoadBack, microcodedPkg::stJump:
                next = microcodedPkg::stFetch;
            microcodedPkg::stHalt:
                next = microcodedPkg::stHalt;
            // fetch, irLoad, loadAddr and store just step
            default:
                next = state + 7'd1;
        endcase
        return next;
    endfunction

    task automatic compareValue(
        input string         what,
        input logic [cw-1:0] expected,
        input logic [cw-1:0] actual
    );
        checks++;
        testChecks++;
        if (actual !== expected) begin
            errors++;
            testErrors++;
            $display("error %s: %s expected %h actual %h",
                     testName(testIndex), what, expected, actual);
        end
    endtask

    always @(posedge clk) begin : sampleEdge
        logic [sw-1:0] expActive;
        logic [cw-1:0] expWord;
        if (reset) begin
            modelState = microcodedPkg::stFetch;
            modelIr = '0;
            modelValid = 1'b1;
        end else if (modelValid) begin
            // undefined states read back as fetch
            expActive = (modelState > microcodedPkg::lastState) ?
                        microcodedPkg::stFetch : modelState;
            expWord = expectedWord(expActive);
            compareValue("activeState", cw'(expActive), cw'(activeState));
            compareValue("controlWord", expWord, controlWord);
            // opcode and rd on top, rs and rt below, imm overlays rs and rt
            compareValue("opcode", cw'(modelIr[15:12]), cw'(opcode));
            compareValue("rd", cw'(modelIr[11:8]), cw'(rd));
            compareValue("rs", cw'(modelIr[7:4]), cw'(rs));
            compareValue("rt", cw'(modelIr[3:0]), cw'(rt));
            compareValue("imm", cw'(modelIr[7:0]), cw'(imm));
            modelState = nextModelState(expActive, memReady, modelIr[15:12]);
            if (expWord[microcodedPkg::irLoadBit]) begin
                modelIr = instruction;
            end
        end
        if (testEnd) begin
            $display("test %s: %0d checks, %0d errors",
                     testName(testIndex), testChecks, testErrors);
            testChecks = 0;
            testErrors = 0;
        end
    end

endmodule

`default_nettype wire

//--- tb/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

// drives random instruction streams into the control unit
module controlUnitTb;

    localparam int testCount = 6;
    // cycle budget per test for the watchdog
    localparam int testCycleBudget = 3000;
    localparam int instrCycleLimit = 200;

    logic        clk = 1'b0;
    logic        reset;
    logic        memReady;
    logic [15:0] instruction;
    logic [44:0] controlWord;
    logic [6:0]  activeState;
    logic [3:0]  opcode;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    logic [7:0]  imm;
    logic [2:0]  testIndex;
    logic        testEnd;
    int          checkCount;
    int          errorCount;
    int          stallCount;

    controlUnit dut0 (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .memReady    (memReady),
        .controlWord (controlWord),
        .activeState (activeState),
        .opcode      (opcode),
        .rd          (rd),
        .rs          (rs),
        .rt          (rt),
        .imm         (imm)
    );

    controlChecker checker0 (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .memReady    (memReady),
        .controlWord (controlWord),
        .activeState (activeState),
        .opcode      (opcode),
        .rd          (rd),
        .rs          (rs),
        .rt          (rt),
        .imm         (imm),
        .testIndex   (testIndex),
        .testEnd     (testEnd),
        .checkCount  (checkCount),
        .errorCount  (errorCount)
    );

    // 4 ns clock
    initial begin
        forever #2 clk = ~clk;
    end

    // watchdog at twice the total budget
    initial begin
        #(testCount * testCycleBudget * 4 * 2);
        $display("run timed out before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    // random operands under a given opcode
    function automatic logic [15:0] randomWord(input logic [3:0] op);
        return {op, 12'($urandom)};
    endfunction

    task automatic applyReset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // one instruction from fetch back to fetch
    task automatic runInstruction(input logic [15:0] word, input logic randomReady);
        int   cycles;
        logic seenDecode;
        cycles = 0;
        seenDecode = 1'b0;
        instruction = word;
        while (!(seenDecode && activeState == microcodedPkg::stFetch) &&
               cycles < instrCycleLimit) begin
            // ready about one cycle in three when random
            memReady = randomReady ? (($urandom % 3) == 0) : 1'b1;
            @(negedge clk);
            if (activeState == microcodedPkg::stDecode) begin
                seenDecode = 1'b1;
            end
            cycles++;
        end
        if (cycles >= instrCycleLimit) begin
            $display("instruction %h did not return to fetch within %0d cycles",
                     word, instrCycleLimit);
            stallCount++;
        end
    endtask

    task automatic waitForState(input logic [6:0] state);
        int cycles;
        cycles = 0;
        while (activeState != state && cycles < instrCycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (activeState != state) begin
            $display("microstate %0d was not reached within %0d cycles",
                     state, instrCycleLimit);
            stallCount++;
        end
    endtask

    // checker prints the test line on this strobe
    task automatic endTest();
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
    endtask

    initial begin : testSequence
        logic [3:0] op;
        void'($urandom(75));
        reset = 1'b1;
        instruction = '0;
        memReady = 1'b0;
        testIndex = 3'd0;
        testEnd = 1'b0;
        stallCount = 0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // resetState holds fetch wait first and then resets mid instruction
        repeat (3) @(negedge clk);
        for (int trial = 0; trial < 8; trial++) begin
            instruction = randomWord(4'($urandom % 11));
            memReady = 1'b1;
            repeat ($urandom_range(7, 1)) @(negedge clk);
            applyReset();
            runInstruction(randomWord(4'($urandom % 11)), 1'b0);
        end
        endTest();

        // fetchDecode over legal opcodes 0 to 10
        testIndex = 3'd1;
        for (int n = 0; n < 40; n++) begin
            runInstruction(randomWord(4'($urandom % 11)), 1'b0);
        end
        endTest();

        // memoryWait with mostly loads and stores
        testIndex = 3'd2;
        for (int n = 0; n < 30; n++) begin
            if (n % 3 == 0) op = 4'd8;
            else if (n % 3 == 1) op = 4'd9;
            else op = 4'($urandom % 11);
            runInstruction(randomWord(op), 1'b1);
        end
        endTest();

        // aluAndJump runs 0 to 7 and 10 twice each
        testIndex = 3'd3;
        for (int n = 0; n < 18; n++) begin
            op = (n % 9 == 8) ? 4'd10 : 4'(n % 9);
            runInstruction(randomWord(op), 1'b0);
        end
        endTest();

        // illegalOpcode covers 11 to 14
        testIndex = 3'd4;
        for (int n = 0; n < 12; n++) begin
            runInstruction(randomWord(4'(11 + n % 4)), 1'b0);
        end
        endTest();

        // haltHold stays halted through random inputs until reset
        testIndex = 3'd5;
        for (int trial = 0; trial < 4; trial++) begin
            instruction = randomWord(4'd15);
            memReady = 1'b1;
            waitForState(microcodedPkg::stHalt);
            repeat ($urandom_range(40, 5)) begin
                memReady = ($urandom % 2) == 0;
                instruction = 16'($urandom);
                @(negedge clk);
            end
            applyReset();
        end
        endTest();

        $display("totals: %0d tests, %0d checks, %0d errors, %0d stalls",
                 testCount, checkCount, errorCount, stallCount);
        if (errorCount == 0 && stallCount == 0 && checkCount > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
